//--- build.f
source/cdc_pkg.sv
source/lane_dispatch.sv
source/cdc_lane_src.sv
source/cdc_lane_dst.sv
source/lane_collect.sv
source/multilane_cdc.sv
test/tb_multilane_cdc.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_multilane_cdc -f build.f -o tb_multilane_cdc || exit 1
out=$(./obj_dir/tb_multilane_cdc)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- source/cdc_lane_dst.sv
// Destination half of one 4-phase lane; data is sampled only after the synchronized req, so async_data_i must settle first
`timescale 1ns/1ps
`default_nettype none

module cdc_lane_dst (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           async_req_i,
  input  wire cdc_pkg::word_t async_data_i,
  output logic                async_ack_o,
  output logic                valid_o,
  input  wire logic           ready_i,
  output cdc_pkg::word_t      data_o
);

  cdc_pkg::dst_state_e                 state_d, state_q;
  logic                                ack_d, ack_q;
  logic [cdc_pkg::SYNC_STAGES-1:0]     req_sync_q;
  logic                                req_synced;
  // Offer from the FSM into the spill buffer
  logic                                data_valid;
  logic                                buf_ready;
  // Spill buffer storage and bookkeeping
  cdc_pkg::word_t                      mem_q [2];
  logic                                wr_ptr_q, rd_ptr_q;
  logic [1:0]                          cnt_q;
  logic                                empty;
  logic                                push, pop;

  // Req crosses from the source clock through a flop chain
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[cdc_pkg::SYNC_STAGES-2:0], async_req_i};
    end
  end

  assign req_synced = req_sync_q[cdc_pkg::SYNC_STAGES-1];

  // 4-phase receiver
  // Ack is raised the cycle after the buffer takes the word
  always_comb begin
    state_d    = state_q;
    data_valid = 1'b0;
    ack_d      = 1'b0;
    case (state_q)
      cdc_pkg::DST_IDLE: begin
        if (req_synced) begin
          data_valid = 1'b1;
          if (buf_ready) begin
            ack_d   = 1'b1;
            state_d = cdc_pkg::DST_WAIT_REQ_DEASSERT;
          end else begin
            state_d = cdc_pkg::DST_WAIT_DOWNSTREAM_ACK;
          end
        end
      end
      cdc_pkg::DST_WAIT_DOWNSTREAM_ACK: begin
        // Buffer full, keep offering until a slot frees
        data_valid = 1'b1;
        if (buf_ready) begin
          ack_d   = 1'b1;
          state_d = cdc_pkg::DST_WAIT_REQ_DEASSERT;
        end
      end
      cdc_pkg::DST_WAIT_REQ_DEASSERT: begin
        ack_d = 1'b1;
        if (!req_synced) begin
          ack_d   = 1'b0;
          state_d = cdc_pkg::DST_IDLE;
        end
      end
      default: state_d = cdc_pkg::DST_IDLE;
    endcase
  end

  // Ack leaves from a flop so the sender never sees a glitch
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cdc_pkg::DST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  assign async_ack_o = ack_q;

  // Two-entry spill buffer
  // When empty and the consumer is ready, the word passes straight through
  assign empty     = (cnt_q == 2'd0);
  assign buf_ready = (cnt_q != 2'd2);
  assign valid_o   = !empty || data_valid;
  assign data_o    = empty ? async_data_i : mem_q[rd_ptr_q];
  assign push      = data_valid && buf_ready && !(empty && ready_i);
  assign pop       = !empty && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      if (push && !pop) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= async_data_i;
    end
  end

  // A stalled word must stay offered with the same value
  a_valid_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("lane output dropped or changed while stalled");

endmodule : cdc_lane_dst

`default_nettype wire

//--- source/cdc_lane_src.sv
// Source half of one 4-phase lane; async_req_o and async_data_o need a max-delay constraint to the other clock
`timescale 1ns/1ps
`default_nettype none

module cdc_lane_src (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           valid_i,
  input  wire cdc_pkg::word_t data_i,
  output logic                ready_o,
  output logic                async_req_o,
  input  wire logic           async_ack_i,
  output cdc_pkg::word_t      async_data_o
);

  cdc_pkg::src_state_e                 state_d, state_q;
  logic                                req_d, req_q;
  cdc_pkg::word_t                      data_q;
  logic [cdc_pkg::SYNC_STAGES-1:0]     ack_sync_q;
  logic                                ack_synced;
  logic                                load;

  // Ack comes from the destination clock, so it passes a flop chain first
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[cdc_pkg::SYNC_STAGES-2:0], async_ack_i};
    end
  end

  assign ack_synced = ack_sync_q[cdc_pkg::SYNC_STAGES-1];

  // 4-phase sender
  // Ready only in idle, which decouples the input from the crossing
  always_comb begin
    state_d = state_q;
    req_d   = 1'b0;
    ready_o = 1'b0;
    case (state_q)
      cdc_pkg::SRC_IDLE: begin
        ready_o = 1'b1;
        if (valid_i) begin
          req_d   = 1'b1;
          state_d = cdc_pkg::SRC_WAIT_ACK_ASSERT;
        end
      end
      cdc_pkg::SRC_WAIT_ACK_ASSERT: begin
        // Hold req until the receiver has taken the word
        req_d = 1'b1;
        if (ack_synced) begin
          req_d   = 1'b0;
          state_d = cdc_pkg::SRC_WAIT_ACK_DEASSERT;
        end
      end
      cdc_pkg::SRC_WAIT_ACK_DEASSERT: begin
        // The cycle ends only once ack is low again on this side
        if (!ack_synced) begin
          state_d = cdc_pkg::SRC_IDLE;
        end
      end
      default: state_d = cdc_pkg::SRC_IDLE;
    endcase
  end

  assign load = ready_o && valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= cdc_pkg::SRC_IDLE;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
    end
  end

  // Data changes only in idle, while req and ack are both low
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  // Both leave straight from flops, so no glitch reaches the other domain
  assign async_req_o  = req_q;
  assign async_data_o = data_q;

  // The receiver samples data at any point while req is high
  a_data_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    async_req_o |=> $stable(async_data_o)
  ) else $error("async data changed while req was high");

endmodule : cdc_lane_src

`default_nettype wire

//--- source/cdc_pkg.sv
// Shared sizes and types for the multi-lane CDC; LANES must be a power of two and SYNC_STAGES at least 2
`default_nettype none

package cdc_pkg;

  // Number of parallel 4-phase crossing lanes
  // Words rotate over the lanes, so throughput scales with this count
  localparam int unsigned LANES = 4;

  // Depth of the flop chain that synchronizes req and ack in each half
  localparam int unsigned SYNC_STAGES = 2;

  // Width of the lane pointer in the dispatcher and the collector
  localparam int unsigned LANE_IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

  // Payload word carried across the boundary
  typedef logic [31:0] word_t;

  // Lane index, wraps through 0 .. LANES-1
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  // Sender states in the source domain
  // The prefix keeps the literals apart from the receiver states
  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WAIT_ACK_ASSERT,
    SRC_WAIT_ACK_DEASSERT
  } src_state_e;

  // Receiver states in the destination domain
  typedef enum logic [1:0] {
    DST_IDLE,
    DST_WAIT_DOWNSTREAM_ACK,
    DST_WAIT_REQ_DEASSERT
  } dst_state_e;

endpackage : cdc_pkg

`default_nettype wire

//--- source/lane_collect.sv
// Destination-domain round-robin merger; order holds only if every lane delivers its words in sequence
`timescale 1ns/1ps
`default_nettype none

module lane_collect (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic           [cdc_pkg::LANES-1:0]     lane_valid_i,
  output logic                [cdc_pkg::LANES-1:0]     lane_ready_o,
  input  wire cdc_pkg::word_t [cdc_pkg::LANES-1:0]     lane_data_i,
  output logic                                         dst_valid_o,
  input  wire logic                                    dst_ready_i,
  output cdc_pkg::word_t                               dst_data_o
);

  // Lane expected to carry the next output word
  cdc_pkg::lane_idx_t ptr_q;
  logic               xfer;

  // Only the selected lane is visible downstream
  // A word waiting on another lane stays there until its turn
  assign dst_valid_o = lane_valid_i[ptr_q];
  assign dst_data_o  = lane_data_i[ptr_q];
  assign xfer        = dst_valid_o && dst_ready_i;

  always_comb begin
    for (int i = 0; i < cdc_pkg::LANES; i++) begin
      lane_ready_o[i] = dst_ready_i && (ptr_q == cdc_pkg::lane_idx_t'(i));
    end
  end

  // Same rotation as the dispatcher, one step per delivered word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (xfer) begin
      if (ptr_q == cdc_pkg::lane_idx_t'(cdc_pkg::LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // Downstream sees a held word until it is taken, whatever the other lanes do
  a_out_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dst_valid_o && !dst_ready_i |=> dst_valid_o && $stable(dst_data_o)
  ) else $error("collector output changed while stalled");

endmodule : lane_collect

`default_nettype wire

//--- source/lane_dispatch.sv
// Source-domain splitter, word k goes to lane k mod LANES; order needs a matching collector
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_ni,
  input  wire logic                                    src_valid_i,
  input  wire cdc_pkg::word_t                          src_data_i,
  output logic                                         src_ready_o,
  output logic          [cdc_pkg::LANES-1:0]           lane_valid_o,
  input  wire logic     [cdc_pkg::LANES-1:0]           lane_ready_i,
  output cdc_pkg::word_t [cdc_pkg::LANES-1:0]          lane_data_o
);

  // Lane that takes the next input word
  cdc_pkg::lane_idx_t ptr_q;
  logic               xfer;

  // The input stream sees only the selected lane's ready
  assign src_ready_o = lane_ready_i[ptr_q];
  assign xfer        = src_valid_i && src_ready_o;

  // Valid goes to the selected lane only
  // Data fans out to every lane, since the others ignore it without valid
  always_comb begin
    for (int i = 0; i < cdc_pkg::LANES; i++) begin
      lane_valid_o[i] = src_valid_i && (ptr_q == cdc_pkg::lane_idx_t'(i));
      lane_data_o[i]  = src_data_i;
    end
  end

  // Step to the next lane after each accepted word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (xfer) begin
      if (ptr_q == cdc_pkg::lane_idx_t'(cdc_pkg::LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // A word waiting for a busy lane must stay offered with the same value
  a_src_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    src_valid_i && !src_ready_o |=> src_valid_i && $stable(src_data_i)
  ) else $error("input word dropped or changed before a lane took it");

endmodule : lane_dispatch

`default_nettype wire

//--- source/multilane_cdc.sv
// Multi-lane 4-phase CDC top; both resets must be applied together, since a one-sided reset can lose words in flight
`timescale 1ns/1ps
`default_nettype none

module multilane_cdc (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  input  wire logic           dst_clk_i,
  input  wire logic           dst_rst_ni,
  input  wire logic           src_valid_i,
  output logic                src_ready_o,
  input  wire cdc_pkg::word_t src_data_i,
  output logic                dst_valid_o,
  input  wire logic           dst_ready_i,
  output cdc_pkg::word_t      dst_data_o
);

  // Dispatcher to senders, source clock
  logic           [cdc_pkg::LANES-1:0] lane_valid;
  logic           [cdc_pkg::LANES-1:0] lane_ready;
  cdc_pkg::word_t [cdc_pkg::LANES-1:0] lane_data;
  // Across the boundary, one 4-phase link per lane
  logic           [cdc_pkg::LANES-1:0] async_req;
  logic           [cdc_pkg::LANES-1:0] async_ack;
  cdc_pkg::word_t [cdc_pkg::LANES-1:0] async_data;
  // Receivers to collector, destination clock
  logic           [cdc_pkg::LANES-1:0] out_valid;
  logic           [cdc_pkg::LANES-1:0] out_ready;
  cdc_pkg::word_t [cdc_pkg::LANES-1:0] out_data;

  lane_dispatch lane_dispatch_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .src_valid_i  (src_valid_i),
    .src_data_i   (src_data_i),
    .src_ready_o  (src_ready_o),
    .lane_valid_o (lane_valid),
    .lane_ready_i (lane_ready),
    .lane_data_o  (lane_data)
  );

  // Each lane pair runs its own handshake, so lanes overlap in time
  for (genvar l = 0; l < cdc_pkg::LANES; l++) begin : gen_lane
    cdc_lane_src cdc_lane_src_i (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .valid_i      (lane_valid[l]),
      .data_i       (lane_data[l]),
      .ready_o      (lane_ready[l]),
      .async_req_o  (async_req[l]),
      .async_ack_i  (async_ack[l]),
      .async_data_o (async_data[l])
    );

    cdc_lane_dst cdc_lane_dst_i (
      .clk_i        (dst_clk_i),
      .rst_ni       (dst_rst_ni),
      .async_req_i  (async_req[l]),
      .async_data_i (async_data[l]),
      .async_ack_o  (async_ack[l]),
      .valid_o      (out_valid[l]),
      .ready_i      (out_ready[l]),
      .data_o       (out_data[l])
    );
  end

  lane_collect lane_collect_i (
    .clk_i        (dst_clk_i),
    .rst_ni       (dst_rst_ni),
    .lane_valid_i (out_valid),
    .lane_ready_o (out_ready),
    .lane_data_i  (out_data),
    .dst_valid_o  (dst_valid_o),
    .dst_ready_i  (dst_ready_i),
    .dst_data_o   (dst_data_o)
  );

endmodule : multilane_cdc

`default_nettype wire

//--- test/tb_multilane_cdc.sv
// Needs a simulator with timing support; the hold test assumes LANES = 4 (12 words in flight)
`timescale 1ns/1ps
`default_nettype none

module tb_multilane_cdc;

  localparam int SRC_PERIOD   = 40;
  localparam int DST_PERIOD   = 56;
  localparam int DRIVE_DELAY  = 2;
  localparam int ROWS         = 24;
  // The output is held low from this row until the input side backs up
  localparam int HOLD_ROW     = 8;
  // A busy lane frees itself within a few synchronizer round trips, far below this
  localparam int BLOCK_CYCLES = 40;
  localparam int TIMEOUT      = 400;
  localparam logic [31:0] LFSR_SEED = 32'hc540_f145;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // One stimulus row holds the word, the idle source cycles before it and the stall flag
  typedef struct packed {
    cdc_pkg::word_t data;
    logic [3:0]     gap;
    logic           stall;
  } row_t;

  logic           clk_i;
  logic           rst_ni;
  logic           dst_clk_i;
  logic           dst_rst_ni;
  logic           src_valid_i;
  logic           src_ready_o;
  cdc_pkg::word_t src_data_i;
  logic           dst_valid_o;
  logic           dst_ready_i;
  cdc_pkg::word_t dst_data_o;

  int             check_errors;
  int             timeouts;
  logic           src_blocked;
  logic           stall_seen;
  cdc_pkg::word_t stall_data;
  logic [31:0]    src_lfsr;
  logic [31:0]    dst_lfsr;

  // Rows 0-7 run back to back, rows 8-15 see output stalls, the rest add source gaps
  row_t tbl [ROWS] = '{
    '{32'h1111_0000, 4'd0, 1'b0}, '{32'h2222_0001, 4'd0, 1'b0},
    '{32'h3333_0002, 4'd0, 1'b0}, '{32'h4444_0003, 4'd0, 1'b0},
    '{32'hdead_beef, 4'd0, 1'b0}, '{32'h0000_0000, 4'd0, 1'b0},
    '{32'hffff_ffff, 4'd0, 1'b0}, '{32'h8000_0001, 4'd0, 1'b0},
    '{32'h0123_4567, 4'd0, 1'b1}, '{32'h89ab_cdef, 4'd0, 1'b1},
    '{32'hfedc_ba98, 4'd0, 1'b1}, '{32'h7654_3210, 4'd0, 1'b1},
    '{32'h5555_aaaa, 4'd0, 1'b1}, '{32'haaaa_5555, 4'd0, 1'b1},
    '{32'hcafe_f00d, 4'd0, 1'b1}, '{32'h1357_9bdf, 4'd0, 1'b1},
    '{32'h2468_ace0, 4'd1, 1'b0}, '{32'h0f0f_f0f0, 4'd3, 1'b1},
    '{32'hc0de_0018, 4'd0, 1'b0}, '{32'h600d_0019, 4'd2, 1'b1},
    '{32'hbead_0020, 4'd1, 1'b0}, '{32'h0bad_0021, 4'd0, 1'b1},
    '{32'h7777_0022, 4'd4, 1'b0}, '{32'h9999_0023, 4'd2, 1'b0}
  };

  multilane_cdc multilane_cdc_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .src_valid_i (src_valid_i),
    .src_ready_o (src_ready_o),
    .src_data_i  (src_data_i),
    .dst_valid_o (dst_valid_o),
    .dst_ready_i (dst_ready_i),
    .dst_data_o  (dst_data_o)
  );

  // Two unrelated clocks whose edges meet only every 280 ns
  initial begin
    clk_i = 1'b0;
    forever #(SRC_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    dst_clk_i = 1'b0;
    forever #(DST_PERIOD / 2) dst_clk_i = ~dst_clk_i;
  end

  // Right-shifting Galois LFSR
  // The caller takes bit 0 before each step
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ LFSR_TAPS;
    end
    return nxt;
  endfunction

  task automatic check_word(input string name, input cdc_pkg::word_t got,
                            input cdc_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h, expected %h", name, got, exp);
      check_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h, expected %h", name, got, exp);
      check_errors++;
    end
  endtask

  // Offer each row in order, after its table gap plus up to three random cycles
  task automatic send_rows;
    int   gap;
    int   extra;
    int   waits;
    int   blocked;
    logic took;
    for (int r = 0; r < ROWS && timeouts == 0; r++) begin
      gap   = int'(tbl[r].gap);
      extra = 0;
      if (gap > 0) begin
        repeat (2) begin
          extra    = (extra << 1) | int'(src_lfsr[0]);
          src_lfsr = lfsr_next(src_lfsr);
        end
      end
      repeat (gap + extra) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
      end
      src_valid_i = 1'b1;
      src_data_i  = tbl[r].data;
      waits       = 0;
      blocked     = 0;
      took        = 1'b0;
      while (!took) begin
        @(posedge clk_i);
        took    = src_ready_o;
        blocked = took ? 0 : blocked + 1;
        #DRIVE_DELAY;
        // A long refusal only happens when every lane is full behind the output
        if (blocked >= BLOCK_CYCLES) src_blocked = 1'b1;
        waits++;
        if (!took && waits >= TIMEOUT) begin
          $display("Timeout: input word %0d was never accepted", r);
          timeouts++;
          src_valid_i = 1'b0;
          return;
        end
      end
      src_valid_i = 1'b0;
    end
  endtask

  // Keep dst_ready_i low until the input side shows it is stuck
  task automatic hold_output;
    int waits;
    waits       = 0;
    dst_ready_i = 1'b0;
    while (!src_blocked && waits < TIMEOUT) begin
      @(posedge dst_clk_i);
      #DRIVE_DELAY;
      waits++;
    end
    if (!src_blocked) begin
      $display("src_ready_o never dropped while dst_ready_i was held low");
      check_errors++;
    end
  endtask

  // Expect the rows in table order, with random stalls on flagged rows
  task automatic receive_rows;
    int   waits;
    logic took;
    for (int r = 0; r < ROWS && timeouts == 0; r++) begin
      if (r == HOLD_ROW) hold_output();
      waits = 0;
      took  = 1'b0;
      while (!took) begin
        if (tbl[r].stall) begin
          dst_ready_i = dst_lfsr[0];
          dst_lfsr    = lfsr_next(dst_lfsr);
        end else begin
          dst_ready_i = 1'b1;
        end
        @(posedge dst_clk_i);
        if (dst_valid_o && dst_ready_i) begin
          check_word("dst_data_o", dst_data_o, tbl[r].data);
          took = 1'b1;
        end
        #DRIVE_DELAY;
        waits++;
        if (!took && waits >= TIMEOUT) begin
          $display("Timeout: output word %0d never arrived", r);
          timeouts++;
          return;
        end
      end
    end
  endtask

  // Nothing may follow the last word
  // A duplicate would show up here
  task automatic check_idle;
    dst_ready_i = 1'b1;
    repeat (20) begin
      @(posedge dst_clk_i);
      check_flag("dst_valid_o", dst_valid_o, 1'b0);
    end
  endtask

  // An offered word that was not taken must be offered again unchanged
  always @(posedge dst_clk_i) begin
    if (dst_rst_ni) begin
      if (stall_seen) begin
        check_flag("dst_valid_o", dst_valid_o, 1'b1);
        check_word("dst_data_o", dst_data_o, stall_data);
      end
      stall_seen = dst_valid_o && !dst_ready_i;
      stall_data = dst_data_o;
    end
  end

  initial begin
    rst_ni       = 1'b0;
    dst_rst_ni   = 1'b0;
    src_valid_i  = 1'b0;
    src_data_i   = '0;
    dst_ready_i  = 1'b0;
    check_errors = 0;
    timeouts     = 0;
    src_blocked  = 1'b0;
    stall_seen   = 1'b0;
    stall_data   = '0;
    src_lfsr     = LFSR_SEED;
    dst_lfsr     = LFSR_SEED;
    // Each reset is released in its own clock domain after three cycles
    fork
      begin
        repeat (3) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
      end
      begin
        repeat (3) @(posedge dst_clk_i);
        #DRIVE_DELAY;
        dst_rst_ni = 1'b1;
      end
    join
    check_flag("src_ready_o", src_ready_o, 1'b1);
    check_flag("dst_valid_o", dst_valid_o, 1'b0);
    fork
      begin
        @(posedge clk_i);
        #DRIVE_DELAY;
        send_rows();
      end
      begin
        @(posedge dst_clk_i);
        #DRIVE_DELAY;
        receive_rows();
        if (timeouts == 0) check_idle();
      end
    join
    $display("Checks failed: %0d, timeouts: %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_multilane_cdc

`default_nettype wire
